// ==== hw/fe_defines.svh ====
`ifndef FE_DEFINES_SVH
`define FE_DEFINES_SVH

// address widths
`define FE_VADDR_W 32
`define FE_PADDR_W 32
`define FE_PAGE_W 12

// bytes per cache line and per fetch block
`define FE_LINE_B 16
`define FE_IC_LINES 16

`define FE_TLB_ENTRIES 4

// in fetch blocks
`define FE_IBUF_DEPTH 4

// credits held at reset
`define FE_L2_CREDITS 1
`define FE_DISP_CREDITS 4

`define FE_PC_INIT 32'h0000_1000

`endif

// ==== hw/fe_pkg.sv ====
`default_nettype none
`include "fe_defines.svh"

package fe_pkg;

  typedef struct packed {
    logic                   valid;
    logic                   upd_pc_vld;
    logic [`FE_VADDR_W-1:0] upd_pc;
    logic                   flush;
  } commit_t;

  typedef struct packed {
    logic                               valid;
    logic [`FE_VADDR_W-`FE_PAGE_W-1:0]  vpn;
    logic [`FE_PADDR_W-`FE_PAGE_W-1:0]  ppn;
  } tlb_fill_t;

  typedef struct packed {
    logic                   hit;
    logic [`FE_PADDR_W-1:0] paddr;
  } tlb_resp_t;

  typedef struct packed {
    logic                   valid;
    logic [`FE_VADDR_W-1:0] vaddr;
  } ic_req_t;

  // one line seen as raw bits or as instruction slots
  typedef union packed {
    logic [`FE_LINE_B*8-1:0]        raw;
    logic [`FE_LINE_B/4-1:0][31:0]  slot;
  } fetch_block_u;

  typedef struct packed {
    logic                   valid;
    logic [`FE_VADDR_W-1:0] addr;
    fetch_block_u           data;
    logic [`FE_LINE_B-1:0]  be;
  } ic_resp_t;

  typedef struct packed {
    logic                   valid;
    logic [`FE_PADDR_W-1:0] paddr;
  } l2_req_t;

  typedef struct packed {
    logic                    valid;
    logic [`FE_LINE_B*8-1:0] data;
  } l2_resp_t;

  typedef struct packed {
    logic                   valid;
    logic [`FE_VADDR_W-1:0] pc;
    logic [31:0]            inst;
  } disp_t;

endpackage

`default_nettype wire

// ==== hw/fe_tlb.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "fe_defines.svh"

module fe_tlb (
  input  wire                     i_clk,
  input  wire                     i_reset_n,
  input  wire [`FE_VADDR_W-1:0]   i_vaddr,
  input  wire fe_pkg::tlb_fill_t  i_fill,
  output fe_pkg::tlb_resp_t       o_resp
);

  localparam int VPN_W = `FE_VADDR_W - `FE_PAGE_W;
  localparam int PPN_W = `FE_PADDR_W - `FE_PAGE_W;
  localparam int IDX_W = $clog2(`FE_TLB_ENTRIES);

  logic [`FE_TLB_ENTRIES-1:0] r_vld;
  logic [VPN_W-1:0]           r_vpn [`FE_TLB_ENTRIES];
  logic [PPN_W-1:0]           r_ppn [`FE_TLB_ENTRIES];
  logic [IDX_W-1:0]           r_rr_ptr;
  logic [`FE_TLB_ENTRIES-1:0] w_hit_vec;
  logic [`FE_TLB_ENTRIES-1:0] w_fill_match;
  logic [PPN_W-1:0]           w_ppn;
  logic [IDX_W-1:0]           w_fill_idx;

  // lookup and fill match across all entries
  always_comb begin
    w_hit_vec    = '0;
    w_fill_match = '0;
    w_ppn        = '0;
    w_fill_idx   = r_rr_ptr;
    for (int i = 0; i < `FE_TLB_ENTRIES; i++) begin
      w_hit_vec[i]    = r_vld[i] & (r_vpn[i] == i_vaddr[`FE_VADDR_W-1:`FE_PAGE_W]);
      w_fill_match[i] = r_vld[i] & (r_vpn[i] == i_fill.vpn);
      if (w_hit_vec[i]) begin
        w_ppn = w_ppn | r_ppn[i];
      end
      if (w_fill_match[i]) begin
        w_fill_idx = IDX_W'(i);
      end
    end
  end

  assign o_resp.hit   = |w_hit_vec;
  assign o_resp.paddr = {w_ppn, i_vaddr[`FE_PAGE_W-1:0]};

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_vld    <= '0;
      r_rr_ptr <= '0;
    end else if (i_fill.valid) begin
      r_vld[w_fill_idx] <= 1'b1;
      // pointer only moves when a new entry is taken
      if (w_fill_match == '0) begin
        r_rr_ptr <= r_rr_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_fill.valid) begin
      r_vpn[w_fill_idx] <= i_fill.vpn;
      r_ppn[w_fill_idx] <= i_fill.ppn;
    end
  end

endmodule

`default_nettype wire

// ==== hw/fe_icache.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "fe_defines.svh"

module fe_icache (
  input  wire                      i_clk,
  input  wire                      i_reset_n,
  input  wire                      i_flush,
  input  wire fe_pkg::ic_req_t     i_s0_req,
  input  wire fe_pkg::tlb_resp_t   i_s1_tlb,
  input  wire                      i_l2_req_credit,
  input  wire fe_pkg::l2_resp_t    i_l2_resp,
  output logic                     o_s0_ready,
  output fe_pkg::ic_resp_t         o_s2_resp,
  output logic                     o_s2_miss,
  output logic [`FE_VADDR_W-1:0]   o_s2_miss_vaddr,
  output fe_pkg::l2_req_t          o_l2_req
);

  localparam int OFF_W  = $clog2(`FE_LINE_B);
  localparam int IDX_W  = $clog2(`FE_IC_LINES);
  localparam int LINE_W = `FE_PADDR_W - OFF_W;
  localparam int TAG_W  = LINE_W - IDX_W;
  localparam int CRD_W  = $clog2(`FE_L2_CREDITS + 1);

  // tag and data arrays
  logic [`FE_IC_LINES-1:0]   r_valid;
  logic [TAG_W-1:0]          r_tag  [`FE_IC_LINES];
  logic [`FE_LINE_B*8-1:0]   r_data [`FE_IC_LINES];
  logic [IDX_W-1:0]          w_s0_idx;

  logic                      r_s1_valid;
  logic [`FE_VADDR_W-1:0]    r_s1_vaddr;
  logic [TAG_W-1:0]          r_s1_tag;
  logic                      r_s1_tag_vld;
  logic [`FE_LINE_B*8-1:0]   r_s1_data;
  logic                      w_s1_tag_hit;

  logic                      r_s2_valid;
  logic [`FE_VADDR_W-1:0]    r_s2_vaddr;
  logic [LINE_W-1:0]         r_s2_line;
  logic                      r_s2_tlb_hit;
  logic                      r_s2_tag_hit;
  logic [`FE_LINE_B*8-1:0]   r_s2_data;
  logic                      w_s2_hit;
  logic                      w_s2_miss;

  logic                      r_busy;
  logic                      r_req_pend;
  logic [LINE_W-1:0]         r_miss_line;
  logic [CRD_W-1:0]          r_l2_credits;
  logic                      w_refill_start;
  logic                      w_refill_done;
  logic                      w_l2_fire;
  logic [IDX_W-1:0]          w_refill_idx;

  assign w_s0_idx = i_s0_req.vaddr[OFF_W+IDX_W-1:OFF_W];

  // ============================
  // s1 tag compare
  // ============================
  assign w_s1_tag_hit = r_s1_tag_vld &
                        (r_s1_tag == i_s1_tlb.paddr[`FE_PADDR_W-1:OFF_W+IDX_W]);

  // ============================
  // s2 hit or miss
  // ============================
  assign w_s2_hit  = r_s2_tlb_hit & r_s2_tag_hit;
  assign w_s2_miss = r_s2_valid & ~w_s2_hit;

  assign o_s2_resp.valid    = r_s2_valid & w_s2_hit;
  assign o_s2_resp.addr     = r_s2_vaddr;
  assign o_s2_resp.data.raw = r_s2_data;
  assign o_s2_resp.be       = {`FE_LINE_B{1'b1}} << r_s2_vaddr[OFF_W-1:0];

  assign o_s2_miss       = w_s2_miss;
  assign o_s2_miss_vaddr = r_s2_vaddr;

  // no new fetch while a refill is out or the replay is being set up
  assign o_s0_ready = ~r_busy & ~w_s2_miss;

  // ============================
  // refill
  // ============================
  // a tlb miss replays without an L2 request
  assign w_refill_start = w_s2_miss & r_s2_tlb_hit;
  assign w_refill_done  = r_busy & i_l2_resp.valid;
  assign w_refill_idx   = r_miss_line[IDX_W-1:0];
  assign w_l2_fire      = r_req_pend & (r_l2_credits != '0);

  assign o_l2_req.valid = w_l2_fire;
  assign o_l2_req.paddr = {r_miss_line, {OFF_W{1'b0}}};

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid      <= '0;
      r_s1_valid   <= 1'b0;
      r_s2_valid   <= 1'b0;
      r_busy       <= 1'b0;
      r_req_pend   <= 1'b0;
      r_l2_credits <= CRD_W'(`FE_L2_CREDITS);
    end else begin
      r_s1_valid <= i_s0_req.valid;
      // a miss squashes the younger fetch behind it
      r_s2_valid <= r_s1_valid & ~w_s2_miss;

      if (i_flush) begin
        r_valid <= '0;
      end else if (w_refill_done) begin
        r_valid[w_refill_idx] <= 1'b1;
      end

      if (w_refill_start) begin
        r_busy <= 1'b1;
      end else if (w_refill_done) begin
        r_busy <= 1'b0;
      end

      if (w_refill_start) begin
        r_req_pend <= 1'b1;
      end else if (w_l2_fire) begin
        r_req_pend <= 1'b0;
      end

      r_l2_credits <= r_l2_credits - CRD_W'(w_l2_fire) + CRD_W'(i_l2_req_credit);
    end
  end

  always_ff @(posedge i_clk) begin
    // s0 array read
    r_s1_vaddr   <= i_s0_req.vaddr;
    r_s1_tag     <= r_tag[w_s0_idx];
    r_s1_tag_vld <= r_valid[w_s0_idx] & ~i_flush;
    r_s1_data    <= r_data[w_s0_idx];

    r_s2_vaddr   <= r_s1_vaddr;
    r_s2_line    <= i_s1_tlb.paddr[`FE_PADDR_W-1:OFF_W];
    r_s2_tlb_hit <= i_s1_tlb.hit;
    r_s2_tag_hit <= w_s1_tag_hit;
    r_s2_data    <= r_s1_data;

    if (w_refill_start) begin
      r_miss_line <= r_s2_line;
    end

    if (w_refill_done) begin
      r_tag[w_refill_idx]  <= r_miss_line[LINE_W-1:IDX_W];
      r_data[w_refill_idx] <= i_l2_resp.data;
    end
  end

endmodule

`default_nettype wire

// ==== hw/fe_inst_buffer.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "fe_defines.svh"

module fe_inst_buffer (
  input  wire                    i_clk,
  input  wire                    i_reset_n,
  input  wire                    i_flush,
  input  wire                    i_inst_vld,
  input  wire fe_pkg::ic_resp_t  i_inst,
  input  wire                    i_disp_credit,
  output logic                   o_inst_rdy,
  output fe_pkg::disp_t          o_disp
);

  localparam int DEPTH     = `FE_IBUF_DEPTH;
  localparam int PTR_W     = $clog2(DEPTH);
  localparam int CNT_W     = $clog2(DEPTH + 1);
  localparam int SLOTS     = `FE_LINE_B / 4;
  localparam int SLOT_W    = $clog2(SLOTS);
  localparam int OFF_W     = $clog2(`FE_LINE_B);
  localparam int CRD_W     = $clog2(`FE_DISP_CREDITS + 1);
  // blocks that can still land after s0 ready is sampled
  localparam int IN_FLIGHT = 2;

  fe_pkg::fetch_block_u      r_data [DEPTH];
  logic [`FE_VADDR_W-1:0]    r_pc   [DEPTH];
  logic [`FE_LINE_B-1:0]     r_be   [DEPTH];

  logic [PTR_W-1:0]          r_wr_ptr;
  logic [PTR_W-1:0]          r_rd_ptr;
  logic [CNT_W-1:0]          r_count;
  logic [SLOTS-1:0]          r_done;
  logic [CRD_W-1:0]          r_credits;

  logic [SLOTS-1:0]          w_slot_en;
  logic [SLOTS-1:0]          w_remain;
  logic [SLOTS-1:0]          w_slot_oh;
  logic [SLOT_W-1:0]         w_slot_idx;
  logic                      w_last;
  logic                      w_head_vld;
  logic                      w_fire;
  logic                      w_retire;
  logic                      w_push;

  // ============================
  // head block slot walk
  // ============================
  always_comb begin
    w_slot_en = '0;
    for (int i = 0; i < SLOTS; i++) begin
      w_slot_en[i] = r_be[r_rd_ptr][4*i];
    end
    w_remain   = w_slot_en & ~r_done;
    w_slot_idx = '0;
    // lowest slot still pending
    for (int i = SLOTS - 1; i >= 0; i--) begin
      if (w_remain[i]) begin
        w_slot_idx = SLOT_W'(i);
      end
    end
    w_slot_oh = SLOTS'(1) << w_slot_idx;
    w_last    = (w_remain & ~w_slot_oh) == '0;
  end

  assign w_head_vld = (r_count != '0) & (|w_remain);
  assign w_fire     = w_head_vld & (r_credits != '0);
  assign w_retire   = (r_count != '0) & ((w_fire & w_last) | ~(|w_remain));
  assign w_push     = i_inst_vld & ~i_flush;

  assign o_disp.valid = w_fire;
  assign o_disp.pc    = {r_pc[r_rd_ptr][`FE_VADDR_W-1:OFF_W], w_slot_idx, 2'b00};
  assign o_disp.inst  = r_data[r_rd_ptr].slot[w_slot_idx];

  assign o_inst_rdy = (int'(r_count) + IN_FLIGHT) < DEPTH;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_wr_ptr  <= '0;
      r_rd_ptr  <= '0;
      r_count   <= '0;
      r_done    <= '0;
      r_credits <= CRD_W'(`FE_DISP_CREDITS);
    end else begin
      r_credits <= r_credits - CRD_W'(w_fire) + CRD_W'(i_disp_credit);
      if (i_flush) begin
        r_wr_ptr <= '0;
        r_rd_ptr <= '0;
        r_count  <= '0;
        r_done   <= '0;
      end else begin
        if (w_push) begin
          r_wr_ptr <= r_wr_ptr + 1'b1;
        end
        if (w_retire) begin
          r_rd_ptr <= r_rd_ptr + 1'b1;
          r_done   <= '0;
        end else if (w_fire) begin
          r_done <= r_done | w_slot_oh;
        end
        r_count <= r_count + CNT_W'(w_push) - CNT_W'(w_retire);
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_push) begin
      r_data[r_wr_ptr] <= i_inst.data;
      r_pc[r_wr_ptr]   <= i_inst.addr;
      r_be[r_wr_ptr]   <= i_inst.be;
    end
  end

endmodule

`default_nettype wire

// ==== hw/fe_frontend.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "fe_defines.svh"

module fe_frontend (
  input  wire                     i_clk,
  input  wire                     i_reset_n,
  input  wire fe_pkg::commit_t    i_commit,
  input  wire fe_pkg::tlb_fill_t  i_tlb_fill,
  input  wire                     i_l2_req_credit,
  input  wire fe_pkg::l2_resp_t   i_l2_resp,
  input  wire                     i_disp_credit,
  output fe_pkg::l2_req_t         o_l2_req,
  output fe_pkg::disp_t           o_disp
);

  localparam int OFF_W = $clog2(`FE_LINE_B);

  logic                    r_s0_valid;
  logic [`FE_VADDR_W-1:0]  r_s0_vaddr;
  logic [`FE_VADDR_W-1:0]  w_s0_vaddr;
  logic [`FE_VADDR_W-1:0]  w_next_block;
  logic                    w_s0_ready;
  logic                    w_ic_s0_ready;
  logic                    w_ibuf_rdy;
  fe_pkg::ic_req_t         w_s0_ic_req;
  fe_pkg::tlb_resp_t       w_s0_tlb_resp;
  fe_pkg::tlb_resp_t       r_s1_tlb_resp;
  fe_pkg::ic_resp_t        w_s2_ic_resp;
  logic                    w_s2_miss;
  logic [`FE_VADDR_W-1:0]  w_s2_miss_vaddr;

  logic                    w_commit_upd_pc;
  logic                    w_flush;
  logic [`FE_VADDR_W-1:0]  r_redirect_pc;
  logic                    r_s2_stale;
  logic                    r_kill;
  logic                    w_resp_killed;

  assign w_commit_upd_pc = i_commit.valid & i_commit.upd_pc_vld;
  assign w_flush         = i_commit.valid & i_commit.flush;

  // ============================
  // s0 pc generation
  // ============================
  assign w_s0_vaddr   = w_commit_upd_pc ? i_commit.upd_pc : r_s0_vaddr;
  assign w_next_block = {w_s0_vaddr[`FE_VADDR_W-1:OFF_W] + 1'b1, {OFF_W{1'b0}}};
  assign w_s0_ready   = w_ic_s0_ready & w_ibuf_rdy;

  assign w_s0_ic_req.valid = r_s0_valid & w_s0_ready;
  assign w_s0_ic_req.vaddr = w_s0_vaddr;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_s0_valid <= 1'b0;
      r_s0_vaddr <= `FE_PC_INIT;
    end else begin
      r_s0_valid <= 1'b1;
      if (w_commit_upd_pc) begin
        r_s0_vaddr <= w_s0_ic_req.valid ? w_next_block : i_commit.upd_pc;
      end else if (w_s2_miss) begin
        // a miss from the old stream goes back to the redirect target
        r_s0_vaddr <= (r_s2_stale | r_kill) ? r_redirect_pc : w_s2_miss_vaddr;
      end else if (w_s0_ic_req.valid) begin
        r_s0_vaddr <= w_next_block;
      end
    end
  end

  // ============================
  // response kill
  // ============================
  // current s2 and the fetch now in s1 predate a redirect
  assign w_resp_killed = w_commit_upd_pc | r_s2_stale | r_kill;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_s2_stale <= 1'b0;
      r_kill     <= 1'b0;
    end else begin
      r_s2_stale <= w_commit_upd_pc;
      if (w_commit_upd_pc & ~w_s0_ic_req.valid) begin
        r_kill <= 1'b1;
      end else if (w_s0_ic_req.valid) begin
        r_kill <= 1'b0;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    r_s1_tlb_resp <= w_s0_tlb_resp;
    if (w_commit_upd_pc) begin
      r_redirect_pc <= i_commit.upd_pc;
    end
  end

  fe_tlb u_tlb (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_vaddr   (w_s0_vaddr),
    .i_fill    (i_tlb_fill),
    .o_resp    (w_s0_tlb_resp)
  );

  fe_icache u_icache (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_flush         (w_flush),
    .i_s0_req        (w_s0_ic_req),
    .i_s1_tlb        (r_s1_tlb_resp),
    .i_l2_req_credit (i_l2_req_credit),
    .i_l2_resp       (i_l2_resp),
    .o_s0_ready      (w_ic_s0_ready),
    .o_s2_resp       (w_s2_ic_resp),
    .o_s2_miss       (w_s2_miss),
    .o_s2_miss_vaddr (w_s2_miss_vaddr),
    .o_l2_req        (o_l2_req)
  );

  fe_inst_buffer u_inst_buffer (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_flush       (w_flush),
    .i_inst_vld    (w_s2_ic_resp.valid & ~w_resp_killed),
    .i_inst        (w_s2_ic_resp),
    .i_disp_credit (i_disp_credit),
    .o_inst_rdy    (w_ibuf_rdy),
    .o_disp        (o_disp)
  );

endmodule

`default_nettype wire

// ==== dv/fe_checker.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "fe_defines.svh"

module fe_checker (
  input wire                   i_clk,
  input wire                   i_reset_n,
  input wire fe_pkg::commit_t  i_commit,
  input wire fe_pkg::l2_req_t  i_l2_req,
  input wire                   i_l2_req_credit,
  input wire fe_pkg::disp_t    i_disp,
  input wire                   i_disp_credit
);

  logic [3:0] r_l2_crd;
  logic [3:0] r_disp_crd;
  int         err_cnt = 0;

  // credits as seen from the ports
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_l2_crd   <= 4'(`FE_L2_CREDITS);
      r_disp_crd <= 4'(`FE_DISP_CREDITS);
    end else begin
      r_l2_crd   <= r_l2_crd - 4'(i_l2_req.valid) + 4'(i_l2_req_credit);
      r_disp_crd <= r_disp_crd - 4'(i_disp.valid) + 4'(i_disp_credit);
    end
  end

  a_l2_credit : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_l2_req.valid |-> r_l2_crd != '0)
    else begin
      $error("L2 request issued with no credit");
      err_cnt++;
    end

  a_disp_credit : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_disp.valid |-> r_disp_crd != '0)
    else begin
      $error("dispatch issued with no credit");
      err_cnt++;
    end

  a_flush_quiet : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (i_commit.valid && i_commit.flush) |=> !i_disp.valid)
    else begin
      $error("dispatch in the cycle after a flush");
      err_cnt++;
    end

endmodule

bind fe_frontend fe_checker u_checker (
  .i_clk           (i_clk),
  .i_reset_n       (i_reset_n),
  .i_commit        (i_commit),
  .i_l2_req        (o_l2_req),
  .i_l2_req_credit (i_l2_req_credit),
  .i_disp          (o_disp),
  .i_disp_credit   (i_disp_credit)
);

`default_nettype wire

// ==== dv/fe_tb.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "fe_defines.svh"

module fe_tb;

  // about 1500 cycles of tests, with margin
  localparam int          TIMEOUT_CYCLES = 4000;
  localparam logic [31:0] KEY_OLD        = 32'hC0DE_0000;
  localparam logic [31:0] KEY_NEW        = 32'hBEEF_0000;

  logic                i_clk;
  logic                i_reset_n;
  fe_pkg::commit_t     commit;
  fe_pkg::tlb_fill_t   tlb_fill;
  logic                l2_req_credit;
  fe_pkg::l2_resp_t    l2_resp;
  logic                disp_credit;
  fe_pkg::l2_req_t     l2_req;
  fe_pkg::disp_t       disp;

  logic [31:0] lfsr_state;
  logic [31:0] mem_key;
  logic        sink_on;
  int          pending_credits;
  int          cycle_cnt;
  int          l2_wait;
  logic [31:0] l2_paddr;
  logic [31:0] disp_pc_q[$];
  logic [31:0] disp_inst_q[$];
  logic [31:0] l2_addr_q[$];

  fe_frontend u_dut (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_commit        (commit),
    .i_tlb_fill      (tlb_fill),
    .i_l2_req_credit (l2_req_credit),
    .i_l2_resp       (l2_resp),
    .i_disp_credit   (disp_credit),
    .o_l2_req        (l2_req),
    .o_disp          (disp)
  );

  always #2 i_clk = ~i_clk;

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic int unsigned rand_bits(input int n);
    int unsigned v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = (v << 1) | lfsr_state[0];
    end
    return v;
  endfunction

  // page map as loaded into the TLB
  function automatic logic [31:0] translate(input logic [31:0] va);
    logic [19:0] ppn;
    case (va[31:12])
      20'h8:   ppn = 20'h2;
      default: ppn = va[31:12];
    endcase
    return {ppn, va[11:0]};
  endfunction

  function automatic logic [127:0] line_data(input logic [31:0] pa, input logic [31:0] key);
    logic [127:0] d;
    for (int i = 0; i < 4; i++) begin
      d[32*i +: 32] = (pa + 32'(4 * i)) ^ key;
    end
    return d;
  endfunction

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1, "run stopped");
  endtask

  // ==============================
  // L2 model, dispatch sink, monitor
  // ==============================
  always @(posedge i_clk) begin
    int ret;
    if (i_reset_n) begin
      l2_resp       <= '0;
      l2_req_credit <= 1'b0;
      assert (!(l2_req.valid && l2_wait > 0))
        else stop_with_failure("L2 request while a refill is outstanding");
      if (l2_wait > 0) begin
        l2_wait--;
        if (l2_wait == 0) begin
          l2_resp       <= '{valid: 1'b1, data: line_data(l2_paddr, mem_key)};
          l2_req_credit <= 1'b1;
        end
      end else if (l2_req.valid) begin
        l2_paddr = l2_req.paddr;
        l2_addr_q.push_back(l2_req.paddr);
        l2_wait = 1 + int'(rand_bits(3));
      end
      // dispatch credits come back after random gaps
      ret = (sink_on && pending_credits > 0 && rand_bits(1) == 1) ? 1 : 0;
      pending_credits = pending_credits + int'(disp.valid) - ret;
      disp_credit <= (ret == 1);
    end
  end

  // a dispatch in the commit cycle belongs to the old stream
  always @(posedge i_clk) begin
    if (i_reset_n) begin
      if (commit.valid) begin
        disp_pc_q.delete();
        disp_inst_q.delete();
      end else if (disp.valid) begin
        disp_pc_q.push_back(disp.pc);
        disp_inst_q.push_back(disp.inst);
      end
    end
  end

  always @(posedge i_clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      stop_with_failure($sformatf("timeout after %0d cycles", cycle_cnt));
    end else if (u_dut.u_checker.err_cnt != 0) begin
      stop_with_failure("bound checker reported an assertion failure");
    end
  end

  // ==============================
  // tasks
  // ==============================
  task automatic wait_cycles(input int n);
    repeat (n) @(posedge i_clk);
  endtask

  task automatic tlb_load(input logic [19:0] vpn, input logic [19:0] ppn);
    @(posedge i_clk);
    tlb_fill <= '{valid: 1'b1, vpn: vpn, ppn: ppn};
    @(posedge i_clk);
    tlb_fill <= '0;
  endtask

  task automatic redirect(input logic [31:0] pc, input logic flush);
    @(posedge i_clk);
    commit <= '{valid: 1'b1, upd_pc_vld: 1'b1, upd_pc: pc, flush: flush};
    @(posedge i_clk);
    commit <= '0;
    @(posedge i_clk);
  endtask

  task automatic check_stream(input logic [31:0] start, input int n, input logic [31:0] key);
    logic [31:0] pc;
    logic [31:0] inst;
    logic [31:0] exp_inst;
    for (int k = 0; k < n; k++) begin
      while (disp_pc_q.size() == 0) @(posedge i_clk);
      pc       = disp_pc_q.pop_front();
      inst     = disp_inst_q.pop_front();
      exp_inst = translate(start + 32'(4 * k)) ^ key;
      assert (pc == start + 32'(4 * k))
        else stop_with_failure($sformatf("[FAIL] %0t disp.pc got %h expected %h",
                                         $time, pc, start + 32'(4 * k)));
      assert (inst == exp_inst)
        else stop_with_failure($sformatf("[FAIL] %0t disp.inst got %h expected %h",
                                         $time, inst, exp_inst));
    end
  endtask

  // drop what was buffered before a redirect without flush
  task automatic skip_to(input logic [31:0] target);
    int skipped;
    skipped = 0;
    forever begin
      while (disp_pc_q.size() == 0) @(posedge i_clk);
      if (disp_pc_q[0] == target) begin
        break;
      end
      void'(disp_pc_q.pop_front());
      void'(disp_inst_q.pop_front());
      skipped++;
      assert (skipped <= 32)
        else stop_with_failure("redirect target never dispatched");
    end
  endtask

  // ==============================
  // directed tests
  // ==============================
  task automatic sequential_fetch;
    int base_reqs;
    check_stream(`FE_PC_INIT, 32, mem_key);
    base_reqs = l2_addr_q.size();
    assert (base_reqs >= 8)
      else stop_with_failure("first pass did not refill from L2");
    // cold cache, so every line of the first pass is requested in order
    for (int i = 0; i < 8; i++) begin
      assert (l2_addr_q[i] == `FE_PC_INIT + 32'(16 * i))
        else stop_with_failure($sformatf("[FAIL] %0t l2_req.paddr got %h expected %h",
                                         $time, l2_addr_q[i],
                                         `FE_PC_INIT + 32'(16 * i)));
    end
    redirect(`FE_PC_INIT, 1'b0);
    skip_to(`FE_PC_INIT);
    check_stream(`FE_PC_INIT, 32, mem_key);
    for (int i = base_reqs; i < l2_addr_q.size(); i++) begin
      assert (!(l2_addr_q[i] >= 32'h1000 && l2_addr_q[i] < 32'h1080))
        else stop_with_failure("second pass missed on a cached line");
    end
  endtask

  task automatic redirect_mid_line;
    redirect(32'h0000_1208, 1'b1);
    check_stream(32'h0000_1208, 12, mem_key);
  endtask

  task automatic dispatch_backpressure;
    sink_on <= 1'b0;
    redirect(32'h0000_1300, 1'b1);
    wait_cycles(80);
    assert (disp_pc_q.size() <= `FE_DISP_CREDITS)
      else stop_with_failure("dispatched more instructions than credits");
    sink_on <= 1'b1;
    check_stream(32'h0000_1300, 24, mem_key);
  endtask

  task automatic cache_flush_refetch;
    redirect(32'h0000_1400, 1'b1);
    while (disp_pc_q.size() == 0) @(posedge i_clk);
    sink_on <= 1'b0;
    wait_cycles(60);
    mem_key <= KEY_NEW;
    redirect(32'h0000_1400, 1'b0);
    sink_on <= 1'b1;
    skip_to(32'h0000_1400);
    // still cached from before the switch
    check_stream(32'h0000_1400, 4, KEY_OLD);
    redirect(32'h0000_1400, 1'b1);
    check_stream(32'h0000_1400, 8, KEY_NEW);
  endtask

  task automatic page_translation;
    redirect(32'h0000_8010, 1'b1);
    check_stream(32'h0000_8010, 8, mem_key);
    redirect(32'h0000_5000, 1'b1);
    wait_cycles(60);
    assert (disp_pc_q.size() == 0)
      else stop_with_failure("dispatch from an unmapped page");
    tlb_load(20'h5, 20'h5);
    check_stream(32'h0000_5000, 8, mem_key);
  endtask

  initial begin
    i_clk           = 1'b0;
    i_reset_n       = 1'b0;
    commit          = '0;
    tlb_fill        = '0;
    l2_req_credit   = 1'b0;
    l2_resp         = '0;
    disp_credit     = 1'b0;
    lfsr_state      = 32'h8249;
    mem_key         = KEY_OLD;
    sink_on         = 1'b1;
    pending_credits = 0;
    cycle_cnt       = 0;
    l2_wait         = 0;
    repeat (16) @(posedge i_clk);
    i_reset_n <= 1'b1;
    tlb_load(20'h1, 20'h1);
    tlb_load(20'h2, 20'h2);
    tlb_load(20'h3, 20'h3);
    tlb_load(20'h8, 20'h2);
    sequential_fetch();
    redirect_mid_line();
    dispatch_backpressure();
    cache_flush_refetch();
    // the page 5 fill evicts page 1 and has to come last
    page_translation();
    if (u_dut.u_checker.err_cnt == 0) begin
      $display("all tests passed");
      $finish;
    end else begin
      stop_with_failure("bound checker reported an assertion failure");
    end
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+hw
hw/fe_pkg.sv
hw/fe_tlb.sv
hw/fe_icache.sv
hw/fe_inst_buffer.sv
hw/fe_frontend.sv
dv/fe_checker.sv
dv/fe_tb.sv

// ==== Bender.yml ====
package:
  name: fe_frontend

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/fe_pkg.sv
      - hw/fe_tlb.sv
      - hw/fe_icache.sv
      - hw/fe_inst_buffer.sv
      - hw/fe_frontend.sv
  - target: test
    include_dirs:
      - hw
    files:
      - dv/fe_checker.sv
      - dv/fe_tb.sv
